/* logic/serv_pkg.sv */
package serv_pkg;

   parameter int XLEN       = 32;
   parameter int REG_ADDR_W = 5;

   typedef logic [XLEN-1:0]       word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   // ALU operation select, LUI passes operand B through
   typedef enum logic [2:0] {
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_SLT,
      OP_SLTU,
      OP_LUI
   } alu_op_e;

   // One entry of the instruction queue
   typedef struct packed {
      word_t     pc;
      alu_op_e   op;
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
      word_t     imm;
      logic      use_imm;
      logic      illegal;
   } decoded_instr_t;

   // AXI4-Lite read address and read data payloads
   typedef struct packed {
      word_t      addr;
      logic [2:0] prot;
   } axil_ar_t;

   typedef struct packed {
      word_t      data;
      logic [1:0] resp;
   } axil_r_t;

   // Retire record, valid for one cycle per instruction
   typedef struct packed {
      logic      valid;
      word_t     pc;
      reg_addr_t rd;
      word_t     result;
      logic      wen;
      logic      illegal;
   } retire_t;

endpackage

/* logic/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode (
   input  serv_pkg::word_t          i_word,
   input  serv_pkg::word_t          i_pc,
   output serv_pkg::decoded_instr_t o_instr
);

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   assign opcode = i_word[6:0];
   assign funct3 = i_word[14:12];
   assign funct7 = i_word[31:25];

   always_comb begin
      o_instr.pc      = i_pc;
      o_instr.rd      = i_word[11:7];
      o_instr.rs1     = i_word[19:15];
      o_instr.rs2     = i_word[24:20];
      o_instr.imm     = {{20{i_word[31]}}, i_word[31:20]};
      o_instr.op      = serv_pkg::OP_ADD;
      o_instr.use_imm = 1'b0;
      o_instr.illegal = 1'b0;

      case (opcode)
         OPC_OP, OPC_OP_IMM: begin
            o_instr.use_imm = (opcode == OPC_OP_IMM);
            case (funct3)
               3'b000:  o_instr.op = serv_pkg::OP_ADD;
               3'b010:  o_instr.op = serv_pkg::OP_SLT;
               3'b011:  o_instr.op = serv_pkg::OP_SLTU;
               3'b100:  o_instr.op = serv_pkg::OP_XOR;
               3'b110:  o_instr.op = serv_pkg::OP_OR;
               3'b111:  o_instr.op = serv_pkg::OP_AND;
               // Shifts
               default: o_instr.illegal = 1'b1;
            endcase
            // Only ADD has a second encoding in funct7
            if (opcode == OPC_OP) begin
               if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                  o_instr.op = serv_pkg::OP_SUB;
               end else if (funct7 != 7'b0000000) begin
                  o_instr.illegal = 1'b1;
               end
            end
         end
         OPC_LUI: begin
            o_instr.op      = serv_pkg::OP_LUI;
            o_instr.use_imm = 1'b1;
            o_instr.imm     = {i_word[31:12], 12'b0};
         end
         default: o_instr.illegal = 1'b1;
      endcase
   end

endmodule

/* logic/instr_fetch.sv */
`timescale 1ns/1ps

module instr_fetch #(
   parameter int              QUEUE_DEPTH = 4,
   parameter serv_pkg::word_t RESET_PC    = '0
) (
   input  logic                                   clk,
   input  logic                                   i_arst_n,
   input  logic                                   i_ar_ready,
   input  logic                                   i_r_valid,
   input  serv_pkg::axil_r_t                      i_r,
   input  logic [$clog2(QUEUE_DEPTH+1)-1:0]       i_free,
   output logic                                   o_ar_valid,
   output serv_pkg::axil_ar_t                     o_ar,
   output logic                                   o_r_ready,
   output logic                                   o_push,
   output serv_pkg::decoded_instr_t               o_instr
);

   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

   serv_pkg::word_t          fetch_pc;
   serv_pkg::word_t          rsp_pc;
   logic                     ar_valid_q;
   logic [CNT_W-1:0]         out_cnt;
   logic [CNT_W:0]           claimed;
   logic                     credit;
   logic                     ar_fire;
   logic                     r_fire;
   serv_pkg::decoded_instr_t dec_instr;

   // Reads in flight plus the one currently offered on AR
   assign claimed = {1'b0, out_cnt} + (CNT_W + 1)'(ar_valid_q);
   assign credit  = {1'b0, i_free} > claimed;

   assign ar_fire = ar_valid_q & i_ar_ready;
   assign r_fire  = i_r_valid & o_r_ready;

   assign o_ar_valid = ar_valid_q;
   assign o_ar       = '{addr: fetch_pc, prot: 3'b000};
   assign o_r_ready  = (out_cnt != '0);
   assign o_push     = r_fire;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         ar_valid_q <= 1'b0;
         fetch_pc   <= RESET_PC;
         rsp_pc     <= RESET_PC;
         out_cnt    <= '0;
      end else begin
         // Hold until accepted, then raise again only with credit left
         ar_valid_q <= (ar_valid_q & ~i_ar_ready) | credit;
         if (ar_fire) begin
            fetch_pc <= fetch_pc + 32'd4;
         end
         // Responses return in order, so the oldest PC is a counter
         if (r_fire) begin
            rsp_pc <= rsp_pc + 32'd4;
         end
         case ({ar_fire, r_fire})
            2'b10:   out_cnt <= out_cnt + 1'b1;
            2'b01:   out_cnt <= out_cnt - 1'b1;
            default: out_cnt <= out_cnt;
         endcase
      end
   end

   instr_decode u_decode (
      .i_word  (i_r.data),
      .i_pc    (rsp_pc),
      .o_instr (dec_instr)
   );

   always_comb begin
      o_instr = dec_instr;
      // SLVERR or DECERR on the fetch
      if (i_r.resp != 2'b00) begin
         o_instr.illegal = 1'b1;
      end
   end

endmodule

/* logic/instr_queue.sv */
`timescale 1ns/1ps

module instr_queue #(
   parameter type T     = logic,
   parameter int  DEPTH = 4
) (
   input  logic                         clk,
   input  logic                         i_arst_n,
   input  logic                         i_push,
   input  T                             i_data,
   input  logic                         i_pop,
   output logic                         o_valid,
   output T                             o_data,
   output logic [$clog2(DEPTH+1)-1:0]   o_free
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   T                 mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_pop;

   // Wrap for depths that are not a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign do_pop  = i_pop & o_valid;
   assign o_valid = (count != '0);
   assign o_data  = mem[rd_ptr];
   assign o_free  = CNT_W'(DEPTH) - count;

   always_ff @(posedge clk) begin
      if (i_push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (i_push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         count <= count + CNT_W'(i_push) - CNT_W'(do_pop);
      end
   end

endmodule

/* logic/serial_alu.sv */
`timescale 1ns/1ps

module serial_alu #(
   parameter int W = 1
) (
   input  logic              clk,
   input  logic              i_arst_n,
   input  logic              i_start,
   input  serv_pkg::alu_op_e i_op,
   input  logic [W-1:0]      i_a,
   input  logic [W-1:0]      i_b,
   input  logic              i_last,
   output logic [W-1:0]      o_res,
   output logic              o_cmp
);

   logic         sub;
   logic         carry_q;
   logic         carry_in;
   logic [W-1:0] b_eff;
   logic [W:0]   sum;
   logic         lt;
   logic         cmp_q;

   // Compares are a subtract whose result is dropped
   assign sub = (i_op == serv_pkg::OP_SUB) || (i_op == serv_pkg::OP_SLT) ||
                (i_op == serv_pkg::OP_SLTU);

   assign b_eff    = sub ? ~i_b : i_b;
   assign carry_in = i_start ? sub : carry_q;
   assign sum      = {1'b0, i_a} + {1'b0, b_eff} + {{W{1'b0}}, carry_in};

   // Valid on the top slice only
   always_comb begin
      if (i_op == serv_pkg::OP_SLTU) begin
         lt = ~sum[W];
      end else if (i_a[W-1] ^ i_b[W-1]) begin
         lt = i_a[W-1];
      end else begin
         lt = sum[W-1];
      end
   end

   always_comb begin
      case (i_op)
         serv_pkg::OP_AND: o_res = i_a & i_b;
         serv_pkg::OP_OR:  o_res = i_a | i_b;
         serv_pkg::OP_XOR: o_res = i_a ^ i_b;
         serv_pkg::OP_LUI: o_res = i_b;
         default:          o_res = sum[W-1:0];
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         carry_q <= 1'b0;
         cmp_q   <= 1'b0;
      end else begin
         carry_q <= sum[W];
         if (i_last) begin
            cmp_q <= lt;
         end
      end
   end

   assign o_cmp = cmp_q;

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
   input  logic                clk,
   input  logic                i_arst_n,
   input  serv_pkg::reg_addr_t i_raddr_a,
   input  serv_pkg::reg_addr_t i_raddr_b,
   input  logic                i_we,
   input  serv_pkg::reg_addr_t i_waddr,
   input  serv_pkg::word_t     i_wdata,
   output serv_pkg::word_t     o_rdata_a,
   output serv_pkg::word_t     o_rdata_b
);

   // x0 has no storage
   serv_pkg::word_t regs [1:31];

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we && i_waddr != '0) begin
         regs[i_waddr] <= i_wdata;
      end
   end

   assign o_rdata_a = (i_raddr_a == '0) ? '0 : regs[i_raddr_a];
   assign o_rdata_b = (i_raddr_b == '0) ? '0 : regs[i_raddr_b];

endmodule

/* logic/serial_exec.sv */
`timescale 1ns/1ps

module serial_exec #(
   parameter int W = 1
) (
   input  logic                     clk,
   input  logic                     i_arst_n,
   input  logic                     i_valid,
   input  serv_pkg::decoded_instr_t i_instr,
   output logic                     o_pop,
   output serv_pkg::retire_t        o_retire
);

   localparam int SLICES = serv_pkg::XLEN / W;
   localparam int CNT_W  = $clog2(SLICES);

   typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_RETIRE} state_e;

   state_e                   state_q;
   logic [CNT_W-1:0]         cnt_q;
   serv_pkg::decoded_instr_t instr_q;
   serv_pkg::word_t          op_a_q;
   serv_pkg::word_t          op_b_q;
   serv_pkg::word_t          res_q;
   serv_pkg::word_t          rdata_a;
   serv_pkg::word_t          rdata_b;
   serv_pkg::word_t          wdata;
   logic [W-1:0]             alu_res;
   logic                     alu_cmp;
   logic                     alu_start;
   logic                     alu_last;
   logic                     is_cmp;
   logic                     wen;
   logic                     rf_we;

   assign o_pop     = (state_q == ST_IDLE) & i_valid;
   assign alu_start = (state_q == ST_RUN) && (cnt_q == '0);
   assign alu_last  = (state_q == ST_RUN) && (cnt_q == CNT_W'(SLICES - 1));

   assign is_cmp = (instr_q.op == serv_pkg::OP_SLT) || (instr_q.op == serv_pkg::OP_SLTU);
   assign wen    = ~instr_q.illegal && (instr_q.rd != '0);
   assign rf_we  = (state_q == ST_RETIRE) & wen;
   assign wdata  = instr_q.illegal ? '0 :
                   is_cmp ? {{(serv_pkg::XLEN-1){1'b0}}, alu_cmp} : res_q;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state_q <= ST_IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               cnt_q <= '0;
               if (o_pop) begin
                  state_q <= ST_RUN;
               end
            end
            ST_RUN: begin
               cnt_q <= cnt_q + 1'b1;
               if (alu_last) begin
                  state_q <= ST_RETIRE;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Operands load on the pop, then shift LSB first
   always_ff @(posedge clk) begin
      if (o_pop) begin
         instr_q <= i_instr;
         op_a_q  <= rdata_a;
         op_b_q  <= i_instr.use_imm ? i_instr.imm : rdata_b;
      end else if (state_q == ST_RUN) begin
         op_a_q <= op_a_q >> W;
         op_b_q <= op_b_q >> W;
         res_q  <= {alu_res, res_q[serv_pkg::XLEN-1:W]};
      end
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_retire <= '0;
      end else begin
         o_retire.valid <= (state_q == ST_RETIRE);
         if (state_q == ST_RETIRE) begin
            o_retire.pc      <= instr_q.pc;
            o_retire.rd      <= instr_q.rd;
            o_retire.result  <= wdata;
            o_retire.wen     <= wen;
            o_retire.illegal <= instr_q.illegal;
         end
      end
   end

   reg_file u_reg_file (
      .clk       (clk),
      .i_arst_n  (i_arst_n),
      .i_raddr_a (i_instr.rs1),
      .i_raddr_b (i_instr.rs2),
      .i_we      (rf_we),
      .i_waddr   (instr_q.rd),
      .i_wdata   (wdata),
      .o_rdata_a (rdata_a),
      .o_rdata_b (rdata_b)
   );

   serial_alu #(
      .W (W)
   ) u_alu (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_start  (alu_start),
      .i_op     (instr_q.op),
      .i_a      (op_a_q[W-1:0]),
      .i_b      (op_b_q[W-1:0]),
      .i_last   (alu_last),
      .o_res    (alu_res),
      .o_cmp    (alu_cmp)
   );

endmodule

/* logic/serial_core_top.sv */
`timescale 1ns/1ps

module serial_core_top #(
   parameter int              W           = 1,
   parameter int              QUEUE_DEPTH = 4,
   parameter serv_pkg::word_t RESET_PC    = '0
) (
   input  logic               clk,
   input  logic               i_arst_n,
   input  logic               i_ar_ready,
   input  logic               i_r_valid,
   input  serv_pkg::axil_r_t  i_r,
   output logic               o_ar_valid,
   output logic               o_r_ready,
   output serv_pkg::axil_ar_t o_ar,
   output serv_pkg::retire_t  o_retire
);

   localparam int FREE_W = $clog2(QUEUE_DEPTH + 1);

   logic                     push;
   serv_pkg::decoded_instr_t push_instr;
   logic [FREE_W-1:0]        free;
   logic                     q_valid;
   serv_pkg::decoded_instr_t q_instr;
   logic                     pop;

   instr_fetch #(
      .QUEUE_DEPTH (QUEUE_DEPTH),
      .RESET_PC    (RESET_PC)
   ) u_fetch (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_ar_ready (i_ar_ready),
      .i_r_valid  (i_r_valid),
      .i_r        (i_r),
      .i_free     (free),
      .o_ar_valid (o_ar_valid),
      .o_ar       (o_ar),
      .o_r_ready  (o_r_ready),
      .o_push     (push),
      .o_instr    (push_instr)
   );

   instr_queue #(
      .T     (serv_pkg::decoded_instr_t),
      .DEPTH (QUEUE_DEPTH)
   ) u_queue (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_push   (push),
      .i_data   (push_instr),
      .i_pop    (pop),
      .o_valid  (q_valid),
      .o_data   (q_instr),
      .o_free   (free)
   );

   serial_exec #(
      .W (W)
   ) u_exec (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_valid  (q_valid),
      .i_instr  (q_instr),
      .o_pop    (pop),
      .o_retire (o_retire)
   );

endmodule

/* testbench/serial_core_checker.sv */
`timescale 1ns/1ps

module serial_core_checker #(
   parameter int W = 1
) (
   input logic               clk,
   input logic               i_arst_n,
   input logic               i_ar_ready,
   input logic               i_r_valid,
   input logic               o_ar_valid,
   input logic               o_r_ready,
   input serv_pkg::axil_ar_t o_ar,
   input serv_pkg::retire_t  o_retire
);

   localparam int GAP = serv_pkg::XLEN / W + 2;

   int outstanding;

   // Reads accepted on AR and not yet answered on R
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         outstanding <= 0;
      end else begin
         outstanding <= outstanding + int'(o_ar_valid && i_ar_ready)
                        - int'(i_r_valid && o_r_ready);
      end
   end

   ar_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
      o_ar_valid && !i_ar_ready |=> o_ar_valid && $stable(o_ar))
      else $error("AR valid dropped or AR payload changed before the transfer");

   r_ready_outstanding: assert property (@(posedge clk) disable iff (!i_arst_n)
      outstanding != 0 |-> o_r_ready)
      else $error("R ready low while a read is outstanding");

   retire_gap: assert property (@(posedge clk) disable iff (!i_arst_n)
      o_retire.valid |=> !o_retire.valid [*(GAP-1)])
      else $error("Retire pulses closer than the serial execution time");

endmodule

/* testbench/serial_core_tb.sv */
`timescale 1ns/1ps

module serial_core_tb;

   localparam int              W           = 1;
   localparam int              QUEUE_DEPTH = 4;
   localparam serv_pkg::word_t RESET_PC    = 32'h0;
   localparam int              MEM_WORDS   = 256;
   localparam int              TOTAL_INSTR = 100;
   localparam int              INSTR_CYC   = 32 / W + 2 + 8;

   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLL  = 3'b001;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

   logic               clk;
   logic               i_arst_n;
   logic               i_ar_ready;
   logic               i_r_valid;
   serv_pkg::axil_r_t  i_r;
   logic               o_ar_valid;
   logic               o_r_ready;
   serv_pkg::axil_ar_t o_ar;
   serv_pkg::retire_t  o_retire;

   serv_pkg::word_t mem [MEM_WORDS];
   logic            slverr [MEM_WORDS];
   serv_pkg::word_t model_regs [32];
   serv_pkg::word_t exp_pc;
   int              retired;
   int              error_count;
   int              check_count;
   int              test_count;
   bit              random_delays;

   // Memory slave state and handshakes sampled at the falling edge
   serv_pkg::word_t pending [$];
   int              ar_wait;
   int              r_wait;
   logic            rst_s;
   logic            ar_fire_s;
   logic            r_fire_s;
   serv_pkg::word_t ar_addr_s;

   initial clk = 1'b0;
   always #20 clk = ~clk;

   serial_core_top #(
      .W           (W),
      .QUEUE_DEPTH (QUEUE_DEPTH),
      .RESET_PC    (RESET_PC)
   ) u_serial_core_top (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_ar_ready (i_ar_ready),
      .i_r_valid  (i_r_valid),
      .i_r        (i_r),
      .o_ar_valid (o_ar_valid),
      .o_r_ready  (o_r_ready),
      .o_ar       (o_ar),
      .o_retire   (o_retire)
   );

   bind serial_core_top serial_core_checker #(.W(W)) u_checker (.*);

   function automatic serv_pkg::word_t reg_op_word(input logic [6:0] f7, input logic [2:0] f3,
                                                   input int rd, input int rs1, input int rs2);
      return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
   endfunction

   function automatic serv_pkg::word_t imm_op_word(input logic [2:0] f3, input int rd,
                                                   input int rs1, input int imm);
      return {12'(imm), 5'(rs1), f3, 5'(rd), 7'b0010011};
   endfunction

   function automatic serv_pkg::word_t lui_word(input int rd, input logic [19:0] upper);
      return {upper, 5'(rd), 7'b0110111};
   endfunction

   function automatic int draw_delay();
      return random_delays ? int'($urandom % 4) : 0;
   endfunction

   // Reference model that executes the word at pc and updates its registers
   function automatic serv_pkg::retire_t predict_retire(input serv_pkg::word_t pc);
      serv_pkg::retire_t want;
      serv_pkg::word_t   word;
      serv_pkg::word_t   a;
      serv_pkg::word_t   b;
      logic [6:0]        opc;
      logic [2:0]        f3;
      logic [6:0]        f7;
      logic              legal;
      word  = mem[pc[9:2]];
      opc   = word[6:0];
      f3    = word[14:12];
      f7    = word[31:25];
      a     = model_regs[word[19:15]];
      b     = (opc == 7'b0010011) ? {{20{word[31]}}, word[31:20]} : model_regs[word[24:20]];
      legal = (f3 != 3'b001) && (f3 != 3'b101);
      if (opc == 7'b0110011) begin
         legal = legal && (f7 == 7'h00 || (f7 == 7'h20 && f3 == F3_ADD));
      end else if (opc == 7'b0110111) begin
         legal = 1'b1;
      end else if (opc != 7'b0010011) begin
         legal = 1'b0;
      end
      legal = legal && !slverr[pc[9:2]];
      want         = '0;
      want.valid   = 1'b1;
      want.pc      = pc;
      want.rd      = word[11:7];
      want.illegal = !legal;
      want.wen     = legal && (word[11:7] != 5'd0);
      if (opc == 7'b0110111) begin
         want.result = {word[31:12], 12'h000};
      end else begin
         case (f3)
            F3_ADD:  want.result = (opc == 7'b0110011 && f7[5]) ? a - b : a + b;
            F3_SLT:  want.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU: want.result = (a < b) ? 32'd1 : 32'd0;
            F3_XOR:  want.result = a ^ b;
            F3_OR:   want.result = a | b;
            F3_AND:  want.result = a & b;
            default: want.result = '0;
         endcase
      end
      if (want.wen) begin
         model_regs[want.rd] = want.result;
      end
      return want;
   endfunction

   task automatic check_word(input string name, input serv_pkg::word_t want,
                             input serv_pkg::word_t got);
      check_count++;
      if (got !== want) begin
         error_count++;
         $display("[ERROR] %s expected 0x%08h got 0x%08h", name, want, got);
      end
   endtask

   task automatic check_retire(input serv_pkg::retire_t want, input serv_pkg::retire_t got);
      check_word("o_retire.pc", want.pc, got.pc);
      check_word("o_retire.rd", 32'(want.rd), 32'(got.rd));
      check_word("o_retire.wen", 32'(want.wen), 32'(got.wen));
      check_word("o_retire.illegal", 32'(want.illegal), 32'(got.illegal));
      // An illegal instruction has no defined result
      if (!want.illegal) begin
         check_word("o_retire.result", want.result, got.result);
      end
   endtask

   always @(negedge clk) begin
      if (i_arst_n && o_retire.valid) begin
         check_retire(predict_retire(exp_pc), o_retire);
         exp_pc = exp_pc + 32'd4;
         retired++;
      end
   end

   always @(negedge clk) begin
      rst_s     = i_arst_n;
      ar_fire_s = o_ar_valid && i_ar_ready;
      ar_addr_s = o_ar.addr;
      r_fire_s  = i_r_valid && o_r_ready;
   end

   // AXI4-Lite slave that answers reads in order after a drawn delay
   task automatic serve_memory();
      if (!rst_s) begin
         pending.delete();
         ar_wait    = 0;
         r_wait     = 0;
         i_ar_ready = 1'b0;
         i_r_valid  = 1'b0;
      end else begin
         if (ar_fire_s) begin
            pending.push_back(ar_addr_s);
            ar_wait = draw_delay();
         end else if (ar_wait > 0) begin
            ar_wait--;
         end
         if (r_fire_s) begin
            void'(pending.pop_front());
            i_r_valid = 1'b0;
            r_wait    = draw_delay();
         end
         if (!i_r_valid && pending.size() > 0) begin
            if (r_wait == 0) begin
               i_r.data  = mem[pending[0][9:2]];
               i_r.resp  = slverr[pending[0][9:2]] ? 2'b10 : 2'b00;
               i_r_valid = 1'b1;
            end else begin
               r_wait--;
            end
         end
         i_ar_ready = (ar_wait == 0);
      end
   endtask

   always @(posedge clk) begin
      #2;
      serve_memory();
   end

   // Called 2 ns after a rising edge
   task automatic load_and_reset(input serv_pkg::word_t prog[$], input int err_index);
      i_arst_n = 1'b0;
      exp_pc   = RESET_PC;
      retired  = 0;
      foreach (model_regs[i]) begin
         model_regs[i] = '0;
      end
      @(posedge clk);
      #2;
      // ADDI x0, x0 with the byte address as immediate
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i]    = {12'(i * 4), 20'h00013};
         slverr[i] = 1'b0;
      end
      foreach (prog[i]) begin
         mem[RESET_PC[9:2] + i] = prog[i];
      end
      if (err_index >= 0) begin
         slverr[err_index] = 1'b1;
      end
      repeat (7) begin
         @(negedge clk);
         check_count++;
         if (o_ar_valid || o_retire.valid || o_r_ready) begin
            error_count++;
            $display("AR valid, R ready or retire valid high while reset is asserted");
         end
         @(posedge clk);
         #2;
      end
      i_arst_n = 1'b1;
   endtask

   task automatic wait_retired(input int n);
      int cycles;
      cycles = 0;
      while (retired < n && cycles < n * INSTR_CYC + 100) begin
         @(posedge clk);
         cycles++;
      end
      if (retired < n) begin
         error_count++;
         $display("Timed out with %0d of %0d instructions retired after %0d cycles",
                  retired, n, cycles);
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      $display("%s: done, %0d errors", name, error_count - errors_before);
   endtask

   task automatic run_program(input string name, input serv_pkg::word_t prog[$],
                              input int err_index);
      int errors_before;
      errors_before = error_count;
      test_count++;
      @(posedge clk);
      #2;
      load_and_reset(prog, err_index);
      wait_retired(prog.size());
      report_test(name, errors_before);
   endtask

   task automatic test_reset();
      serv_pkg::word_t prog[$];
      int              errors_before;
      errors_before = error_count;
      test_count++;
      prog = '{imm_op_word(F3_ADD, 1, 0, 5), imm_op_word(F3_ADD, 2, 1, -7)};
      @(posedge clk);
      #2;
      load_and_reset(prog, -1);
      @(negedge clk);
      check_count++;
      if (o_ar_valid || o_retire.valid || o_r_ready) begin
         error_count++;
         $display("AR valid, R ready or retire valid high right after reset release");
      end
      // First AR is raised one cycle after release and not yet accepted
      @(negedge clk);
      check_count++;
      if (!o_ar_valid || o_r_ready) begin
         error_count++;
         $display("AR valid low or R ready high one cycle after reset release");
      end
      check_word("o_ar.addr", RESET_PC, o_ar.addr);
      check_word("o_ar.prot", 32'h0, 32'(o_ar.prot));
      wait_retired(prog.size());
      report_test("reset", errors_before);
   endtask

   task automatic test_imm_ops();
      serv_pkg::word_t prog[$];
      prog = '{lui_word(1, 20'h12345),
               imm_op_word(F3_ADD, 1, 1, 'h678),
               imm_op_word(F3_ADD, 2, 0, -2048),
               imm_op_word(F3_AND, 3, 1, 'h0ff),
               imm_op_word(F3_OR, 4, 2, 'h7ff),
               imm_op_word(F3_XOR, 5, 1, -1),
               lui_word(6, 20'hfffff),
               imm_op_word(F3_ADD, 7, 6, -1)};
      run_program("immediate_ops", prog, -1);
   endtask

   task automatic test_reg_ops();
      serv_pkg::word_t prog[$];
      prog = '{lui_word(1, 20'h80000),
               imm_op_word(F3_ADD, 2, 0, -1),
               reg_op_word(7'h00, F3_ADD, 3, 1, 2),
               reg_op_word(7'h20, F3_ADD, 4, 0, 1),
               reg_op_word(7'h00, F3_ADD, 5, 1, 1),
               reg_op_word(7'h20, F3_ADD, 6, 3, 2),
               reg_op_word(7'h00, F3_AND, 7, 3, 2),
               reg_op_word(7'h00, F3_OR, 8, 1, 3),
               reg_op_word(7'h00, F3_XOR, 9, 2, 1)};
      run_program("register_ops", prog, -1);
   endtask

   task automatic test_compares();
      serv_pkg::word_t prog[$];
      prog = '{lui_word(1, 20'h80000),
               imm_op_word(F3_ADD, 1, 1, -1),
               lui_word(2, 20'h80000),
               imm_op_word(F3_ADD, 3, 0, -1),
               imm_op_word(F3_ADD, 4, 0, 1),
               reg_op_word(7'h00, F3_SLT, 5, 2, 1),
               reg_op_word(7'h00, F3_SLT, 6, 1, 2),
               reg_op_word(7'h00, F3_SLTU, 7, 2, 1),
               reg_op_word(7'h00, F3_SLTU, 8, 1, 2),
               imm_op_word(F3_SLT, 9, 3, 0),
               imm_op_word(F3_SLTU, 10, 4, -1),
               imm_op_word(F3_SLTU, 11, 3, 1),
               reg_op_word(7'h00, F3_SLT, 12, 3, 3),
               imm_op_word(F3_SLT, 13, 2, -2048)};
      run_program("compares", prog, -1);
   endtask

   task automatic test_zero_and_illegal();
      serv_pkg::word_t prog[$];
      // Entry 6 is answered with SLVERR and entry 7 is a load
      prog = '{imm_op_word(F3_ADD, 1, 0, 'h55),
               imm_op_word(F3_ADD, 0, 1, 5),
               reg_op_word(7'h00, F3_ADD, 2, 0, 0),
               imm_op_word(F3_ADD, 3, 1, 1),
               reg_op_word(7'h00, F3_SLL, 3, 1, 1),
               imm_op_word(F3_SLL, 3, 1, 2),
               imm_op_word(F3_ADD, 3, 0, 99),
               32'h0000_2183,
               reg_op_word(7'h01, F3_ADD, 3, 1, 1),
               reg_op_word(7'h00, F3_ADD, 4, 3, 0),
               reg_op_word(7'h00, F3_OR, 5, 0, 0),
               reg_op_word(7'h20, F3_ADD, 0, 1, 3),
               reg_op_word(7'h00, F3_ADD, 6, 0, 1)};
      run_program("zero_and_illegal", prog, RESET_PC[9:2] + 6);
   endtask

   task automatic test_back_pressure();
      serv_pkg::word_t prog[$];
      logic [2:0]      f3_set [6];
      logic [2:0]      f3;
      int              rd;
      int              rs1;
      int              rs2;
      f3_set = '{F3_ADD, F3_SLT, F3_SLTU, F3_XOR, F3_OR, F3_AND};
      for (int i = 0; i < 48; i++) begin
         rd  = 1 + int'($urandom % 7);
         rs1 = int'($urandom % 8);
         rs2 = int'($urandom % 8);
         f3  = f3_set[$urandom % 6];
         case ($urandom % 4)
            0:       prog.push_back(imm_op_word(f3, rd, rs1, int'($urandom)));
            1:       prog.push_back(reg_op_word(7'h00, f3, rd, rs1, rs2));
            2:       prog.push_back(reg_op_word(7'h20, F3_ADD, rd, rs1, rs2));
            default: prog.push_back(lui_word(rd, 20'($urandom)));
         endcase
      end
      random_delays = 1'b1;
      run_program("back_pressure", prog, -1);
      random_delays = 1'b0;
   endtask

   initial begin
      #((TOTAL_INSTR * INSTR_CYC + 600) * 40);
      $display("Watchdog expired before all tests finished");
      $display("Test failed");
      $finish;
   end

   initial begin
      void'($urandom(32'h6eac));
      i_arst_n      = 1'b0;
      i_ar_ready    = 1'b0;
      i_r_valid     = 1'b0;
      i_r           = '0;
      rst_s         = 1'b0;
      random_delays = 1'b0;
      exp_pc        = RESET_PC;
      retired       = 0;
      error_count   = 0;
      check_count   = 0;
      test_count    = 0;
      ar_wait       = 0;
      r_wait        = 0;
      test_reset();
      test_imm_ops();
      test_reg_ops();
      test_compares();
      test_zero_and_illegal();
      test_back_pressure();
      $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* serial_core_top.f */
logic/serv_pkg.sv
logic/instr_decode.sv
logic/instr_fetch.sv
logic/instr_queue.sv
logic/serial_alu.sv
logic/reg_file.sv
logic/serial_exec.sv
logic/serial_core_top.sv
testbench/serial_core_checker.sv
testbench/serial_core_tb.sv

/* Bender.yml */
package:
  name: serial_core

sources:
  - logic/serv_pkg.sv
  - logic/instr_decode.sv
  - logic/instr_fetch.sv
  - logic/instr_queue.sv
  - logic/serial_alu.sv
  - logic/reg_file.sv
  - logic/serial_exec.sv
  - logic/serial_core_top.sv
  - target: test
    files:
      - testbench/serial_core_checker.sv
      - testbench/serial_core_tb.sv
